//--- Bender.yml
package:
  name: rob_slice

sources:
  - rtl/rob_pkg.sv
  - rtl/dispatch_unit.sv
  - rtl/rob.sv
  - rtl/retire_unit.sv
  - rtl/rob_top.sv
  - target: simulation
    files:
      - sim/rob_checker.sv
      - sim/tb_rob_top.sv

//--- rtl/dispatch_unit.sv
// dispatch unit
//   compacts sparse valid lanes, lowest lane first
//   limits the accepted count to the free space in the buffer
//   assigns wrapped tags and drives compacted payloads to the buffer

`timescale 1ns/1ps

module dispatch_unit
    import rob_pkg::*;
#(
    parameter int PUSH_WIDTH = DEF_PUSH_WIDTH,
    parameter int ELEMENTS   = DEF_ELEMENTS,
    localparam int SLOTS     = ELEMENTS + 1,
    localparam int TAG_W     = $clog2(ELEMENTS + 1),
    localparam int CNT_W     = $clog2(PUSH_WIDTH + 1)
) (
    // front end
    input  logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] in_payload,
    input  logic [PUSH_WIDTH-1:0]                in_valid,
    output logic [CNT_W-1:0]                     in_accept_ct,
    output logic [PUSH_WIDTH-1:0][TAG_W-1:0]     in_tags,

    // buffer side
    input  logic [CNT_W-1:0]                     free_ct,
    input  logic [TAG_W-1:0]                     next_tag,
    output logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] push_payload,
    output logic [CNT_W-1:0]                     push_ct
);

    logic [CNT_W-1:0] valid_ct;  // set bits in in_valid
    logic [CNT_W-1:0] slot;      // running position in the compacted list

    // ------------------------------------------------------------
    // acceptance count
    // ------------------------------------------------------------
    always_comb begin
        valid_ct = '0;
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            valid_ct = valid_ct + CNT_W'(in_valid[i]);
        end
    end

    assign in_accept_ct = (valid_ct < free_ct) ? valid_ct : free_ct;
    assign push_ct      = in_accept_ct;

    // ------------------------------------------------------------
    // lane compaction
    // ------------------------------------------------------------
    // every valid lane moves down to the count of valid lanes below it;
    // only the first in_accept_ct of them are passed on
    always_comb begin
        slot         = '0;
        push_payload = '0;
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            if (in_valid[i]) begin
                if (slot < in_accept_ct) begin
                    push_payload[slot] = in_payload[i];
                end
                slot = slot + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // tags
    // ------------------------------------------------------------
    // lane k of in_tags belongs to the k-th valid input lane
    always_comb begin
        for (int k = 0; k < PUSH_WIDTH; k++) begin
            in_tags[k] = TAG_W'(wrap_idx(next_tag, k, SLOTS));
        end
    end

endmodule

//--- rtl/retire_unit.sv
// retire unit
//   turns retire_en and the head done run into a take count
//   commits taken entries in program order to the architectural
//   register file, later lanes overriding earlier ones
//   combinational register read port

`timescale 1ns/1ps

module retire_unit
    import rob_pkg::*;
#(
    parameter int PUSH_WIDTH = DEF_PUSH_WIDTH,
    localparam int CNT_W     = $clog2(PUSH_WIDTH + 1)
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 retire_en,

    // buffer head
    input  logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] head_payload,
    input  logic [CNT_W-1:0]                     head_done_ct,
    output logic [CNT_W-1:0]                     take_ct,

    // retire observation
    output logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] retire_payload,
    output logic [CNT_W-1:0]                     retire_ct,

    // architectural read port
    input  logic [REG_IDX_W-1:0]                 arch_raddr,
    output logic [VALUE_W-1:0]                   arch_rdata
);

    logic [VALUE_W-1:0] arch_regs [NUM_ARCH_REGS];

    // ------------------------------------------------------------
    // take count
    // ------------------------------------------------------------
    always_comb begin
        if (!retire_en) begin
            take_ct = '0;
        end else if (head_done_ct > PUSH_WIDTH) begin
            take_ct = CNT_W'(PUSH_WIDTH);
        end else begin
            take_ct = head_done_ct;
        end
    end

    assign retire_ct = take_ct;

    // lanes past the take count read as zero
    always_comb begin
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            retire_payload[i] = (i < take_ct) ? head_payload[i] : '0;
        end
    end

    // ------------------------------------------------------------
    // architectural register file
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                arch_regs[r] <= '0;
            end
        end else begin
            // lane order is program order, the last write to a register wins
            for (int i = 0; i < PUSH_WIDTH; i++) begin
                if (i < take_ct) begin
                    arch_regs[head_payload[i][PAYLOAD_W-1 -: REG_IDX_W]] <=
                        head_payload[i][VALUE_W-1:0];
                end
            end
        end
    end

    assign arch_rdata = arch_regs[arch_raddr];

endmodule

//--- rtl/rob.sv
// reorder buffer
//   circular store of payload and done flag, one slot always free
//   multi-entry write at the tail, done flags set by tag from the
//   completion ports, head read pointer advanced by the retire count
//   free count and done run at the head for dispatch and retire

`timescale 1ns/1ps

module rob
    import rob_pkg::*;
#(
    parameter int PUSH_WIDTH  = DEF_PUSH_WIDTH,
    parameter int ELEMENTS    = DEF_ELEMENTS,
    parameter int CMPLT_WIDTH = DEF_CMPLT_WIDTH,
    localparam int SLOTS      = ELEMENTS + 1,
    localparam int TAG_W      = $clog2(ELEMENTS + 1),
    localparam int CNT_W      = $clog2(PUSH_WIDTH + 1)
) (
    input  logic                                 clk,
    input  logic                                 rst,

    // dispatch side
    input  logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] push_payload,
    input  logic [CNT_W-1:0]                     push_ct,
    output logic [CNT_W-1:0]                     free_ct,
    output logic [TAG_W-1:0]                     next_tag,

    // completion ports
    input  logic [CMPLT_WIDTH-1:0][TAG_W-1:0]    cmplt_tag,
    input  logic [CMPLT_WIDTH-1:0]               cmplt_valid,

    // retire side
    output logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] head_payload,
    output logic [CNT_W-1:0]                     head_done_ct,
    input  logic [CNT_W-1:0]                     take_ct
);

    // ------------------------------------------------------------
    // storage and pointers
    // ------------------------------------------------------------
    logic [PAYLOAD_W-1:0] payload_mem [SLOTS];
    logic [SLOTS-1:0]     done_q;

    logic [TAG_W-1:0] rd_ptr;  // oldest entry
    logic [TAG_W-1:0] wr_ptr;  // next free slot

    logic [TAG_W-1:0] used_ct;
    logic [TAG_W-1:0] free_slots;

    logic [PUSH_WIDTH-1:0][TAG_W-1:0] wr_idx;    // tail slots for this cycle
    logic [PUSH_WIDTH-1:0][TAG_W-1:0] head_idx;  // head slots for this cycle
    logic                             run_open;

    // ------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------
    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            used_ct = wr_ptr - rd_ptr;
        end else begin
            used_ct = TAG_W'(SLOTS - int'(rd_ptr) + int'(wr_ptr));  // tail has wrapped
        end
    end

    assign free_slots = TAG_W'(ELEMENTS) - used_ct;
    assign free_ct    = (free_slots >= PUSH_WIDTH) ? CNT_W'(PUSH_WIDTH) : CNT_W'(free_slots);
    assign next_tag   = wr_ptr;

    // ------------------------------------------------------------
    // slot indices at tail and head
    // ------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < PUSH_WIDTH; k++) begin
            wr_idx[k]   = TAG_W'(wrap_idx(wr_ptr, k, SLOTS));
            head_idx[k] = TAG_W'(wrap_idx(rd_ptr, k, SLOTS));
        end
    end

    // ------------------------------------------------------------
    // head offer
    // ------------------------------------------------------------
    // count done entries from the head until the first one still
    // in flight; stale done flags past the tail are masked by used_ct
    always_comb begin
        run_open     = 1'b1;
        head_done_ct = '0;
        for (int i = 0; i < PUSH_WIDTH; i++) begin
            head_payload[i] = payload_mem[head_idx[i]];
            if (run_open && (i < used_ct) && done_q[head_idx[i]]) begin
                head_done_ct = head_done_ct + 1'b1;
            end else begin
                run_open = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // pointers and done flags
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            done_q <= '0;
        end else begin
            // new entries start not done
            for (int k = 0; k < PUSH_WIDTH; k++) begin
                if (k < push_ct) begin
                    done_q[wr_idx[k]] <= 1'b0;
                end
            end
            // completions only name occupied slots, never a tail slot
            for (int j = 0; j < CMPLT_WIDTH; j++) begin
                if (cmplt_valid[j]) begin
                    done_q[cmplt_tag[j]] <= 1'b1;
                end
            end
            wr_ptr <= TAG_W'(wrap_idx(wr_ptr, push_ct, SLOTS));
            rd_ptr <= TAG_W'(wrap_idx(rd_ptr, take_ct, SLOTS));
        end
    end

    // payload store
    always_ff @(posedge clk) begin
        for (int k = 0; k < PUSH_WIDTH; k++) begin
            if (k < push_ct) begin
                payload_mem[wr_idx[k]] <= push_payload[k];
            end
        end
    end

endmodule

//--- rtl/rob_pkg.sv
// shared constants for the reorder buffer slice
//   architectural register file geometry
//   payload layout (register index in the upper bits, value below)
//   default lane, depth and completion port counts
//   pointer wrap helper used by dispatch and the buffer

package rob_pkg;

    // ------------------------------------------------------------
    // architectural state and payload layout
    // ------------------------------------------------------------
    localparam int NUM_ARCH_REGS = 8;
    localparam int REG_IDX_W     = $clog2(NUM_ARCH_REGS);  // 3 bits
    localparam int VALUE_W       = 7;
    localparam int PAYLOAD_W     = REG_IDX_W + VALUE_W;    // {reg idx, value}

    // ------------------------------------------------------------
    // default geometry, overridden from the top level
    // ------------------------------------------------------------
    localparam int DEF_PUSH_WIDTH  = 4;
    localparam int DEF_ELEMENTS    = 15;  // usable entries, one slot kept spare
    localparam int DEF_CMPLT_WIDTH = 3;

    // add an offset to a circular index with slots entries
    // offset never exceeds slots, so one subtraction is enough
    function automatic int unsigned wrap_idx(int unsigned base, int unsigned ofs,
                                             int unsigned slots);
        int unsigned sum;
        sum = base + ofs;
        if (sum >= slots) begin
            sum = sum - slots;
        end
        return sum;
    endfunction

endpackage

//--- rtl/rob_top.sv
// reorder buffer slice top level
//   dispatch unit, reorder buffer and retire unit
//   geometry parameters set here and passed down

`timescale 1ns/1ps

module rob_top
    import rob_pkg::*;
#(
    parameter int PUSH_WIDTH  = DEF_PUSH_WIDTH,
    parameter int ELEMENTS    = DEF_ELEMENTS,
    parameter int CMPLT_WIDTH = DEF_CMPLT_WIDTH,
    localparam int TAG_W      = $clog2(ELEMENTS + 1),
    localparam int CNT_W      = $clog2(PUSH_WIDTH + 1)
) (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] in_payload,
    input  logic [PUSH_WIDTH-1:0]                in_valid,
    output logic [CNT_W-1:0]                     in_accept_ct,
    output logic [PUSH_WIDTH-1:0][TAG_W-1:0]     in_tags,

    input  logic [CMPLT_WIDTH-1:0][TAG_W-1:0]    cmplt_tag,
    input  logic [CMPLT_WIDTH-1:0]               cmplt_valid,

    input  logic                                 retire_en,
    output logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] retire_payload,
    output logic [CNT_W-1:0]                     retire_ct,

    input  logic [REG_IDX_W-1:0]                 arch_raddr,
    output logic [VALUE_W-1:0]                   arch_rdata
);

    // ------------------------------------------------------------
    // internal links
    // ------------------------------------------------------------
    logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] push_payload;  // compacted lanes
    logic [CNT_W-1:0]                     push_ct;
    logic [CNT_W-1:0]                     free_ct;
    logic [TAG_W-1:0]                     next_tag;
    logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] head_payload;
    logic [CNT_W-1:0]                     head_done_ct;
    logic [CNT_W-1:0]                     take_ct;

    dispatch_unit #(
        .PUSH_WIDTH (PUSH_WIDTH),
        .ELEMENTS   (ELEMENTS)
    ) dispatch0 (
        .in_payload   (in_payload),
        .in_valid     (in_valid),
        .in_accept_ct (in_accept_ct),
        .in_tags      (in_tags),
        .free_ct      (free_ct),
        .next_tag     (next_tag),
        .push_payload (push_payload),
        .push_ct      (push_ct)
    );

    rob #(
        .PUSH_WIDTH  (PUSH_WIDTH),
        .ELEMENTS    (ELEMENTS),
        .CMPLT_WIDTH (CMPLT_WIDTH)
    ) rob0 (
        .clk          (clk),
        .rst          (rst),
        .push_payload (push_payload),
        .push_ct      (push_ct),
        .free_ct      (free_ct),
        .next_tag     (next_tag),
        .cmplt_tag    (cmplt_tag),
        .cmplt_valid  (cmplt_valid),
        .head_payload (head_payload),
        .head_done_ct (head_done_ct),
        .take_ct      (take_ct)
    );

    retire_unit #(
        .PUSH_WIDTH (PUSH_WIDTH)
    ) retire0 (
        .clk            (clk),
        .rst            (rst),
        .retire_en      (retire_en),
        .head_payload   (head_payload),
        .head_done_ct   (head_done_ct),
        .take_ct        (take_ct),
        .retire_payload (retire_payload),
        .retire_ct      (retire_ct),
        .arch_raddr     (arch_raddr),
        .arch_rdata     (arch_rdata)
    );

endmodule

//--- sim.f
rtl/rob_pkg.sv
rtl/dispatch_unit.sv
rtl/rob.sv
rtl/retire_unit.sv
rtl/rob_top.sv
sim/rob_checker.sv
sim/tb_rob_top.sv

//--- sim/rob_checker.sv
// testbench checker for the reorder buffer slice
//   program-order model of dispatched entries and their done flags
//   model architectural register file
//   compares accept count, tags, retire count, retire lanes and register reads

`timescale 1ns/1ps

module rob_checker
    import rob_pkg::*;
#(
    parameter int PUSH_WIDTH  = DEF_PUSH_WIDTH,
    parameter int ELEMENTS    = DEF_ELEMENTS,
    parameter int CMPLT_WIDTH = DEF_CMPLT_WIDTH,
    localparam int TAG_W      = $clog2(ELEMENTS + 1),
    localparam int CNT_W      = $clog2(PUSH_WIDTH + 1)
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] in_payload,
    input  logic [PUSH_WIDTH-1:0]                in_valid,
    input  logic [CNT_W-1:0]                     in_accept_ct,
    input  logic [PUSH_WIDTH-1:0][TAG_W-1:0]     in_tags,
    input  logic [CMPLT_WIDTH-1:0][TAG_W-1:0]    cmplt_tag,
    input  logic [CMPLT_WIDTH-1:0]               cmplt_valid,
    input  logic                                 retire_en,
    input  logic [PUSH_WIDTH-1:0][PAYLOAD_W-1:0] retire_payload,
    input  logic [CNT_W-1:0]                     retire_ct,
    input  logic [REG_IDX_W-1:0]                 arch_raddr,
    input  logic [VALUE_W-1:0]                   arch_rdata,
    input  int                                   exp_accept,  // -1: model decides
    output logic [ELEMENTS-1:0][TAG_W-1:0]       pend_tag,    // not done, oldest first
    output int                                   pend_ct,
    output int                                   q_ct,
    output int                                   err_ct,
    output int                                   check_ct
);

    logic [PAYLOAD_W-1:0] q_pay [$];  // program order
    logic [TAG_W-1:0]     q_tag [$];
    bit                   q_done [$];
    logic [VALUE_W-1:0]   model_regs [NUM_ARCH_REGS];
    int                   next_tag;

    initial begin
        err_ct   = 0;
        check_ct = 0;
        pend_ct  = 0;
        q_ct     = 0;
    end

    task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] got);
        check_ct++;
        if (exp !== got) begin
            err_ct++;
            $display("FAILED %s exp %h got %h", sig, exp, got);
        end
    endtask

    // ------------------------------------------------------------
    // per-edge model update and compare
    // ------------------------------------------------------------
    always @(posedge clk) begin : sample
        int                   occ;
        int                   run;
        int                   exp_ret;
        int                   vcnt;
        int                   exp_acc;
        int                   slot;
        logic [PAYLOAD_W-1:0] pay;
        if (rst) begin
            q_pay.delete();
            q_tag.delete();
            q_done.delete();
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                model_regs[r] = '0;
            end
            next_tag = 0;
        end else begin
            occ = q_pay.size();
            compare("arch_rdata", model_regs[arch_raddr], arch_rdata);

            // retire sees the done flags from before this edge
            run = 0;
            while (run < occ && run < PUSH_WIDTH && q_done[run]) begin
                run++;
            end
            exp_ret = retire_en ? run : 0;
            compare("retire_ct", exp_ret, retire_ct);
            for (int i = 0; i < exp_ret; i++) begin
                compare($sformatf("retire_payload[%0d]", i), q_pay[i], retire_payload[i]);
            end
            for (int i = 0; i < exp_ret; i++) begin
                pay = q_pay.pop_front();  // oldest first, so later writes win
                model_regs[pay[PAYLOAD_W-1 -: REG_IDX_W]] = pay[VALUE_W-1:0];
                void'(q_tag.pop_front());
                void'(q_done.pop_front());
            end

            for (int j = 0; j < CMPLT_WIDTH; j++) begin
                for (int e = 0; e < q_tag.size(); e++) begin
                    if (cmplt_valid[j] && q_tag[e] == cmplt_tag[j]) begin
                        q_done[e] = 1'b1;
                    end
                end
            end

            // dispatch limited by space before this edge
            vcnt = 0;
            for (int i = 0; i < PUSH_WIDTH; i++) begin
                vcnt += int'(in_valid[i]);
            end
            exp_acc = vcnt;
            if (ELEMENTS - occ < exp_acc) begin
                exp_acc = ELEMENTS - occ;
            end
            if (PUSH_WIDTH < exp_acc) begin
                exp_acc = PUSH_WIDTH;
            end
            compare("in_accept_ct", exp_acc, in_accept_ct);
            if (exp_accept >= 0) begin
                compare("in_accept_ct", exp_accept, in_accept_ct);  // table value
            end
            slot = 0;
            for (int i = 0; i < PUSH_WIDTH; i++) begin
                if (in_valid[i] && slot < exp_acc) begin
                    compare($sformatf("in_tags[%0d]", slot),
                            (next_tag + slot) % (ELEMENTS + 1), in_tags[slot]);
                    q_pay.push_back(in_payload[i]);
                    q_tag.push_back(TAG_W'((next_tag + slot) % (ELEMENTS + 1)));
                    q_done.push_back(1'b0);
                    slot++;
                end
            end
            next_tag = (next_tag + exp_acc) % (ELEMENTS + 1);
        end

        // outstanding list handed back to the stimulus
        pend_ct  = 0;
        pend_tag = '0;
        for (int e = 0; e < q_tag.size(); e++) begin
            if (!q_done[e]) begin
                pend_tag[pend_ct] = q_tag[e];
                pend_ct++;
            end
        end
        q_ct = q_tag.size();
    end

endmodule

//--- sim/tb_rob_top.sv
// testbench top for the reorder buffer slice
//   clock, reset and LFSR payload source
//   stimulus table applied row by row with hold counts
//   drain phase, register sweep, timeout and final report

`timescale 1ns/1ps

module tb_rob_top
    import rob_pkg::*;
();

    localparam int PW       = DEF_PUSH_WIDTH;
    localparam int ELEMS    = DEF_ELEMENTS;
    localparam int CW       = DEF_CMPLT_WIDTH;
    localparam int TAG_W    = $clog2(ELEMS + 1);
    localparam int CNT_W    = $clog2(PW + 1);
    localparam int ANY      = -1;  // accept count left to the checker model
    localparam int MAX_ROWS = 32;
    localparam int DRAIN    = 4 * ELEMS + NUM_ARCH_REGS + 16;

    logic                         clk;
    logic                         rst;
    logic [PW-1:0][PAYLOAD_W-1:0] in_payload;
    logic [PW-1:0]                in_valid;
    logic [CNT_W-1:0]             in_accept_ct;
    logic [PW-1:0][TAG_W-1:0]     in_tags;
    logic [CW-1:0][TAG_W-1:0]     cmplt_tag;
    logic [CW-1:0]                cmplt_valid;
    logic                         retire_en;
    logic [PW-1:0][PAYLOAD_W-1:0] retire_payload;
    logic [CNT_W-1:0]             retire_ct;
    logic [REG_IDX_W-1:0]         arch_raddr;
    logic [VALUE_W-1:0]           arch_rdata;
    int                           exp_accept;
    logic [ELEMS-1:0][TAG_W-1:0]  pend_tag;
    int                           pend_ct;
    int                           q_ct;
    int                           err_ct;
    int                           check_ct;

    // stimulus table, one entry per row
    int                  row_test  [MAX_ROWS];
    logic [PW-1:0]       row_valid [MAX_ROWS];
    bit                  row_rnd   [MAX_ROWS];  // payload from the LFSR
    logic [PW*PAYLOAD_W-1:0] row_pay [MAX_ROWS];
    logic [CW-1:0]       row_cmask [MAX_ROWS];
    logic [4*CW-1:0]     row_cidx  [MAX_ROWS];  // index into outstanding list, 4 bits per port
    bit                  row_ren   [MAX_ROWS];
    int                  row_exp   [MAX_ROWS];
    int                  row_hold  [MAX_ROWS];
    int                  n_rows = 0;
    string               test_name [7];

    logic [15:0] lfsr;
    int          cycles = 0;
    int          limit = 0;

    rob_top dut0 (.*);

    rob_checker chk0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not end within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic add_row(input int test, input logic [PW-1:0] valid, input bit rnd,
                           input logic [PW*PAYLOAD_W-1:0] pay, input logic [CW-1:0] cmask,
                           input logic [4*CW-1:0] cidx, input bit ren, input int exp,
                           input int hold);
        row_test[n_rows]  = test;
        row_valid[n_rows] = valid;
        row_rnd[n_rows]   = rnd;
        row_pay[n_rows]   = pay;
        row_cmask[n_rows] = cmask;
        row_cidx[n_rows]  = cidx;
        row_ren[n_rows]   = ren;
        row_exp[n_rows]   = exp;
        row_hold[n_rows]  = hold;
        n_rows++;
    endtask

    task automatic drive_completions(input logic [CW-1:0] cmask, input logic [4*CW-1:0] cidx);
        for (int j = 0; j < CW; j++) begin
            cmplt_valid[j] = cmask[j] && (pend_ct > 0);
            cmplt_tag[j]   = (pend_ct > 0) ? pend_tag[int'(cidx[4*j +: 4]) % pend_ct] : '0;
        end
    endtask

    task automatic drive_row(input int r);
        logic [PW*PAYLOAD_W-1:0] pay;
        pay = row_pay[r];
        if (row_rnd[r]) begin
            for (int b = 0; b < PW * PAYLOAD_W; b++) begin
                lfsr   = lfsr_step(lfsr);
                pay[b] = lfsr[0];
            end
        end
        in_valid   = row_valid[r];
        in_payload = pay;
        retire_en  = row_ren[r];
        exp_accept = row_exp[r];
        arch_raddr = arch_raddr + 1'b1;  // rotate through the read port
        drive_completions(row_cmask[r], row_cidx[r]);
    endtask

    task automatic report_test(input int t, input int errs_before);
        $display("test %0d %s: %0d mismatches", t, test_name[t], err_ct - errs_before);
    endtask

    // ------------------------------------------------------------
    // table: test, valid, rnd, payload, cmask, cidx, ren, expected accept, hold
    // ------------------------------------------------------------
    task automatic load_table();
        test_name = '{"sparse lanes", "full buffer", "in-order retire", "retire hold",
                      "register commit", "wraparound", "drain and register sweep"};
        // lanes alternate r2 and r3, so every group of four retires a repeat
        add_row(0, 4'b0101, 0, {3'd3, 7'h14, 3'd2, 7'h13, 3'd3, 7'h12, 3'd2, 7'h11}, 0, 0, 0, 2, 1);
        add_row(0, 4'b1010, 0, {3'd3, 7'h24, 3'd2, 7'h23, 3'd3, 7'h22, 3'd2, 7'h21}, 0, 0, 0, 2, 1);
        add_row(0, 4'b1001, 0, {3'd3, 7'h34, 3'd2, 7'h33, 3'd3, 7'h32, 3'd2, 7'h31}, 0, 0, 0, 2, 1);
        add_row(0, 4'b0110, 0, {3'd3, 7'h44, 3'd2, 7'h43, 3'd3, 7'h42, 3'd2, 7'h41}, 0, 0, 0, 2, 1);
        add_row(1, 4'b1111, 1, '0, 0, 0, 0, 4, 1);
        add_row(1, 4'b1111, 1, '0, 0, 0, 0, 3, 1);  // 3 slots left
        add_row(1, 4'b1111, 1, '0, 0, 0, 0, 0, 3);
        add_row(1, 4'b0001, 1, '0, 0, 0, 0, 0, 1);
        add_row(2, 4'b0000, 0, '0, 3'b011, {4'd0, 4'd3, 4'd2}, 1, 0, 1);  // younger ones first
        add_row(2, 4'b0000, 0, '0, 3'b001, {4'd0, 4'd0, 4'd1}, 1, 0, 1);
        add_row(2, 4'b0000, 0, '0, 3'b001, {4'd0, 4'd0, 4'd0}, 1, 0, 2);  // head done, 4 go
        add_row(3, 4'b0000, 0, '0, 3'b111, {4'd2, 4'd1, 4'd0}, 0, 0, 3);
        add_row(3, 4'b0000, 0, '0, 3'b000, 0, 1, 0, 3);
        add_row(4, 4'b1111, 0, {3'd5, 7'h54, 3'd5, 7'h53, 3'd5, 7'h52, 3'd5, 7'h51}, 3'b111,
                {4'd2, 4'd1, 4'd0}, 0, 4, 1);
        add_row(4, 4'b0000, 0, '0, 3'b111, {4'd2, 4'd1, 4'd0}, 1, 0, 2);
        add_row(4, 4'b0000, 0, '0, 3'b000, 0, 1, 0, 2);
        add_row(5, 4'b1111, 1, '0, 3'b111, {4'd1, 4'd4, 4'd2}, 1, ANY, 24);
        add_row(5, 4'b1011, 1, '0, 3'b101, {4'd0, 4'd0, 4'd3}, 1, ANY, 16);
        add_row(5, 4'b1111, 1, '0, 3'b111, {4'd5, 4'd0, 4'd1}, 0, ANY, 4);
        add_row(5, 4'b0111, 1, '0, 3'b111, {4'd2, 4'd1, 4'd0}, 1, ANY, 24);
    endtask

    initial begin
        int t_err;
        clk         = 1'b0;
        rst         = 1'b1;
        in_payload  = '0;
        in_valid    = '0;
        cmplt_tag   = '0;
        cmplt_valid = '0;
        retire_en   = 1'b0;
        arch_raddr  = '0;
        exp_accept  = ANY;
        lfsr        = 16'd4943;
        load_table();
        limit = 4 + DRAIN;
        for (int r = 0; r < n_rows; r++) begin
            limit += row_hold[r];
        end

        repeat (4) @(negedge clk);
        rst   = 1'b0;
        t_err = 0;
        for (int r = 0; r < n_rows; r++) begin
            for (int h = 0; h < row_hold[r]; h++) begin
                @(negedge clk);
                if (h == 0 && r > 0 && row_test[r] != row_test[r-1]) begin
                    report_test(row_test[r-1], t_err);
                    t_err = err_ct;
                end
                drive_row(r);
            end
        end
        @(negedge clk);
        report_test(row_test[n_rows-1], t_err);
        t_err = err_ct;

        // complete whatever is left and let it retire
        in_valid   = '0;
        retire_en  = 1'b1;
        exp_accept = ANY;
        while (q_ct != 0) begin
            drive_completions(3'b111, {4'd2, 4'd1, 4'd0});
            @(negedge clk);
        end
        cmplt_valid = '0;
        for (int a = 0; a < NUM_ARCH_REGS; a++) begin
            arch_raddr = REG_IDX_W'(a);
            @(negedge clk);
        end
        report_test(6, t_err);

        if (check_ct == 0) begin
            $display("no checks were made");
        end
        $display("checks %0d, errors %0d", check_ct, err_ct);
        if (err_ct == 0 && check_ct > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
